//--- cpu_defs.svh
/* Widths, instruction field positions and code points of the microcoded CPU.
   Include wherever a field is sliced or a code is decoded */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define CPU_ADDR_W   16
`define CPU_DATA_W   8
`define CPU_INSTR_W  48
`define RAM_ADDR_W   8      // 256 bytes of data RAM

// ----------------------------------------
// Instruction fields, LSB of each
`define F_IMMED      0      // 8 bits
`define F_DIR_LO     8      // Direct address low byte
`define F_DIR_HI     16     // Direct address high byte
`define F_AMODE      24     // 0 register, 1 direct
`define F_INVERT     27     // Flip the condition
`define F_SET_FLAGS  28
`define F_COND       29     // 4 bits
`define F_BBUS       33     // 3 bits
`define F_ABUS       36     // 3 bits
`define F_TARG       39     // 4 bits
`define F_ALU_OP     43     // 5 bits

// ----------------------------------------
// Register codes, shared by A bus, B bus and target
`define DEV_REGA     0
`define DEV_REGB     1
`define DEV_REGC     2
`define DEV_REGD     3
`define DEV_MARLO    4
`define DEV_MARHI    5
`define ADEV_RAM     6
`define ADEV_ZERO    7
`define BDEV_IMMED   6
`define BDEV_RAM     7
`define TDEV_RAM     6
`define TDEV_UART    7
`define TDEV_PCHITMP 8
`define TDEV_PC      9
`define TDEV_HALT    10     // Highest target that writes anything

// Conditions, 10 to 15 never true
`define COND_ALWAYS  0
`define COND_C       1
`define COND_Z       2
`define COND_O       3
`define COND_N       4
`define COND_GT      5
`define COND_LT      6
`define COND_EQ      7
`define COND_NE      8
`define COND_DO      9

// ALU operations, unlisted codes pass B
`define ALU_ZERO     0
`define ALU_A        1
`define ALU_B        2
`define ALU_ADD      3
`define ALU_SUB      4      // A-B
`define ALU_RSUB     5      // B-A
`define ALU_ADDC     6
`define ALU_SUBC     7
`define ALU_AND      8
`define ALU_OR       9
`define ALU_XOR      10
`define ALU_NOT_A    11
`define ALU_INC      12
`define ALU_DEC      13
`define ALU_MUL      14     // Low byte only
`define ALU_SHL      15
`define ALU_SHR      16

// Flag bit positions, czonGLEN from the top
`define FLAG_C       7
`define FLAG_Z       6
`define FLAG_O       5
`define FLAG_N       4
`define FLAG_GT      3
`define FLAG_LT      2
`define FLAG_EQ      1
`define FLAG_NE      0

`endif

//--- cpu_pkg.sv
/* Vector types shared across the CPU core blocks.
   Referenced as cpu_pkg::name from each module */
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_W-1:0]  addr_t;   // Program or RAM address
    typedef logic [`CPU_DATA_W-1:0]  byte_t;   // Data value on either bus
    typedef logic [`CPU_INSTR_W-1:0] instr_t;  // One microcode word

    typedef logic [4:0] alu_op_t;
    typedef logic [2:0] dev_t;     // A or B bus source
    typedef logic [3:0] targ_t;    // Result destination
    typedef logic [3:0] cond_t;

    // carry zero overflow negative GT LT EQ NE, top bit down
    typedef logic [7:0] flags_t;

endpackage

`default_nettype wire

//--- program_rom.sv
/* Program store, 64K words of 48 bits. Loaded through the write port
   while the core is stopped, read combinationally at pc */
`default_nettype none

`include "cpu_defs.svh"

module program_rom (
    input  wire                   clk,
    input  wire                   prog_we,     // One word per strobe
    input  wire cpu_pkg::addr_t   prog_addr,
    input  wire cpu_pkg::instr_t  prog_data,
    input  wire cpu_pkg::addr_t   pc,
    output cpu_pkg::instr_t       instr
);

    cpu_pkg::instr_t mem [2**`CPU_ADDR_W];   // Full 16-bit space

    // Load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign instr = mem[pc];   // Fetch is same cycle

endmodule

`default_nettype wire

//--- controller.sv
/* Instruction decode for the core. Slices the word, picks the condition,
   gates execution and produces one-hot device selects and the RAM address */
`default_nettype none

`include "cpu_defs.svh"

module controller (
    input  wire cpu_pkg::instr_t  instr,
    input  wire cpu_pkg::flags_t  flags,
    input  wire                   out_ready,   // DO flag
    input  wire                   run,
    input  wire                   halted,
    input  wire cpu_pkg::byte_t   marlo,
    input  wire cpu_pkg::byte_t   marhi,
    output cpu_pkg::alu_op_t      alu_op,
    output logic [7:0]            a_sel,       // One-hot A source
    output logic [7:0]            b_sel,       // One-hot B source
    output cpu_pkg::byte_t        immed,
    output logic [15:0]           targ_we,     // One-hot, already gated by exec
    output logic                  set_flags,
    output cpu_pkg::byte_t        ram_addr
);

    cpu_pkg::byte_t  dir_lo;
    cpu_pkg::byte_t  dir_hi;
    logic            amode;
    logic            invert;
    logic            set_flags_bit;
    cpu_pkg::cond_t  cond;
    cpu_pkg::dev_t   abus_dev;
    cpu_pkg::dev_t   bbus_dev;
    cpu_pkg::targ_t  targ_dev;
    logic [15:0]     cond_vec;
    logic            cond_met;
    logic            exec;
    cpu_pkg::addr_t  mem_addr;

    // ----------------------------------------
    // Field split
    assign immed         = instr[`F_IMMED +: `CPU_DATA_W];
    assign dir_lo        = instr[`F_DIR_LO +: `CPU_DATA_W];
    assign dir_hi        = instr[`F_DIR_HI +: `CPU_DATA_W];
    assign amode         = instr[`F_AMODE];
    assign invert        = instr[`F_INVERT];
    assign set_flags_bit = instr[`F_SET_FLAGS];
    assign cond          = instr[`F_COND +: $bits(cpu_pkg::cond_t)];
    assign bbus_dev      = instr[`F_BBUS +: $bits(cpu_pkg::dev_t)];
    assign abus_dev      = instr[`F_ABUS +: $bits(cpu_pkg::dev_t)];
    assign targ_dev      = instr[`F_TARG +: $bits(cpu_pkg::targ_t)];
    assign alu_op        = instr[`F_ALU_OP +: $bits(cpu_pkg::alu_op_t)];

    // ----------------------------------------
    // 16-way condition mux
    always_comb begin
        cond_vec              = '0;              // Unused codes never fire
        cond_vec[`COND_ALWAYS] = 1'b1;
        cond_vec[`COND_C]     = flags[`FLAG_C];
        cond_vec[`COND_Z]     = flags[`FLAG_Z];
        cond_vec[`COND_O]     = flags[`FLAG_O];
        cond_vec[`COND_N]     = flags[`FLAG_N];
        cond_vec[`COND_GT]    = flags[`FLAG_GT];
        cond_vec[`COND_LT]    = flags[`FLAG_LT];
        cond_vec[`COND_EQ]    = flags[`FLAG_EQ];
        cond_vec[`COND_NE]    = flags[`FLAG_NE];
        cond_vec[`COND_DO]    = out_ready;       // Output side can take a byte
    end

    assign cond_met = cond_vec[cond];

    // Invert lets "spin while not DO" be a single instruction
    assign exec      = run && !halted && (cond_met ^ invert);
    assign set_flags = exec && set_flags_bit;   // Skipped instructions leave flags alone

    // ----------------------------------------
    // Device decoders
    assign a_sel = 8'b1 << abus_dev;
    assign b_sel = 8'b1 << bbus_dev;

    always_comb begin
        targ_we = '0;
        // Codes above halt are no-op targets
        if (exec && (targ_dev <= 4'(`TDEV_HALT))) begin
            targ_we[targ_dev] = 1'b1;
        end
    end

    // Register mode uses the MAR pair, direct mode the address in the word
    assign mem_addr = amode ? {dir_hi, dir_lo} : {marhi, marlo};
    assign ram_addr = mem_addr[`RAM_ADDR_W-1:0];   // RAM only decodes the low byte

endmodule

`default_nettype wire

//--- alu.sv
/* Combinational 8-bit ALU. Computes the selected operation on the A and B
   buses and the czonGLEN flags; the flags register decides whether to keep them */
`default_nettype none

`include "cpu_defs.svh"

module alu (
    input  wire cpu_pkg::byte_t   a,
    input  wire cpu_pkg::byte_t   b,
    input  wire                   carry_in,   // Stored carry flag
    input  wire cpu_pkg::alu_op_t op,
    output cpu_pkg::byte_t        result,
    output cpu_pkg::flags_t       flags_out
);

    logic [8:0]     wide;      // Bit 8 is carry out or borrow
    logic           ovf;
    cpu_pkg::byte_t product;   // Only the low byte is kept

    assign product = a * b;

    always_comb begin
        wide = '0;
        ovf  = 1'b0;   // Overflow only for the add/subtract group
        case (op)
            `ALU_ZERO:  wide = '0;
            `ALU_A:     wide = {1'b0, a};
            `ALU_B:     wide = {1'b0, b};
            `ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                ovf  = (a[7] == b[7]) && (wide[7] != a[7]);
            end
            `ALU_SUB: begin
                wide = {1'b0, a} - {1'b0, b};
                ovf  = (a[7] != b[7]) && (wide[7] != a[7]);
            end
            `ALU_RSUB: begin
                wide = {1'b0, b} - {1'b0, a};
                ovf  = (a[7] != b[7]) && (wide[7] != b[7]);
            end
            `ALU_ADDC: begin
                wide = {1'b0, a} + {1'b0, b} + {8'b0, carry_in};
                ovf  = (a[7] == b[7]) && (wide[7] != a[7]);
            end
            `ALU_SUBC: begin
                wide = {1'b0, a} - {1'b0, b} - {8'b0, carry_in};   // Borrow wraps into bit 8
                ovf  = (a[7] != b[7]) && (wide[7] != a[7]);
            end
            `ALU_AND:   wide = {1'b0, a & b};
            `ALU_OR:    wide = {1'b0, a | b};
            `ALU_XOR:   wide = {1'b0, a ^ b};
            `ALU_NOT_A: wide = {1'b0, ~a};
            `ALU_INC:   wide = {1'b0, a} + 9'd1;
            `ALU_DEC:   wide = {1'b0, a} - 9'd1;    // Borrow when A is 0
            `ALU_MUL:   wide = {1'b0, product};
            `ALU_SHL:   wide = {a, 1'b0};           // Top bit falls into carry
            `ALU_SHR:   wide = {2'b0, a[7:1]};
            default:    wide = {1'b0, b};
        endcase
    end

    assign result = wide[7:0];

    // ----------------------------------------
    // Flags
    always_comb begin
        flags_out           = '0;
        flags_out[`FLAG_C]  = wide[8];
        flags_out[`FLAG_Z]  = (result == '0);
        flags_out[`FLAG_O]  = ovf;
        flags_out[`FLAG_N]  = result[7];
        // Compare group is unsigned A against B whatever the op
        flags_out[`FLAG_GT] = (a > b);
        flags_out[`FLAG_LT] = (a < b);
        flags_out[`FLAG_EQ] = (a == b);
        flags_out[`FLAG_NE] = (a != b);
    end

endmodule

`default_nettype wire

//--- register_file.sv
/* General registers, memory address pair, flags and the output port.
   Each one loads the ALU result at the edge when its target strobe is set */
`default_nettype none

`include "cpu_defs.svh"

module register_file (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [15:0]            targ_we,     // One-hot write strobes
    input  wire                   set_flags,
    input  wire cpu_pkg::byte_t   result,
    input  wire cpu_pkg::flags_t  alu_flags,
    output cpu_pkg::byte_t        rega,
    output cpu_pkg::byte_t        regb,
    output cpu_pkg::byte_t        regc,
    output cpu_pkg::byte_t        regd,
    output cpu_pkg::byte_t        marlo,
    output cpu_pkg::byte_t        marhi,
    output cpu_pkg::flags_t       flags,
    output cpu_pkg::byte_t        out_data,
    output logic                  out_valid    // One cycle per uart write
);

    always_ff @(posedge clk) begin
        if (rst) begin
            rega      <= '0;
            regb      <= '0;
            regc      <= '0;
            regd      <= '0;
            marlo     <= '0;
            marhi     <= '0;
            flags     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (targ_we[`DEV_REGA])  rega  <= result;
            if (targ_we[`DEV_REGB])  regb  <= result;
            if (targ_we[`DEV_REGC])  regc  <= result;
            if (targ_we[`DEV_REGD])  regd  <= result;
            if (targ_we[`DEV_MARLO]) marlo <= result;
            if (targ_we[`DEV_MARHI]) marhi <= result;
            if (set_flags) begin
                flags <= alu_flags;   // Strobe already includes exec
            end
            out_valid <= targ_we[`TDEV_UART];   // Drops again next cycle
        end
    end

    // Output byte, only meaningful alongside out_valid
    always_ff @(posedge clk) begin
        if (targ_we[`TDEV_UART]) begin
            out_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- data_ram.sv
/* 256-byte data RAM. Read is combinational so an operand can come from
   RAM in the same instruction; write lands at the clock edge */
`default_nettype none

`include "cpu_defs.svh"

module data_ram (
    input  wire                  clk,
    input  wire                  we,
    input  wire cpu_pkg::byte_t  addr,
    input  wire cpu_pkg::byte_t  wdata,
    output cpu_pkg::byte_t       rdata
);

    cpu_pkg::byte_t mem [2**`RAM_ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];   // Old value while a write is pending

endmodule

`default_nettype wire

//--- program_counter.sv
/* Program counter with its high-byte staging register and the halt flag.
   A jump loads pchitmp first, then writes the low byte to pc */
`default_nettype none

`include "cpu_defs.svh"

module program_counter (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  run,
    input  wire [15:0]           targ_we,
    input  wire cpu_pkg::byte_t  result,
    output cpu_pkg::addr_t       pc,
    output logic                 halted    // Sticky until reset
);

    cpu_pkg::byte_t pchitmp;   // High byte of the next jump

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            pchitmp <= '0;
            halted  <= 1'b0;
        end else begin
            if (targ_we[`TDEV_PCHITMP]) begin
                pchitmp <= result;
            end
            if (targ_we[`TDEV_HALT]) begin
                halted <= 1'b1;   // pc still steps past the halt word
            end

            if (targ_we[`TDEV_PC]) begin
                pc <= {pchitmp, result};               // Jump
            end else if (run && !halted) begin
                pc <= pc + cpu_pkg::addr_t'(1);        // Skipped instructions also step
            end
        end
    end

endmodule

`default_nettype wire

//--- cpu_core.sv
/* Top level of the execution core. Wires the program store, decoder, ALU,
   registers, RAM and pc together and holds the A and B bus muxes */
`default_nettype none

`include "cpu_defs.svh"

module cpu_core (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   run,
    input  wire                   prog_we,
    input  wire cpu_pkg::addr_t   prog_addr,
    input  wire cpu_pkg::instr_t  prog_data,
    input  wire                   out_ready,
    output cpu_pkg::byte_t        out_data,
    output logic                  out_valid,
    output logic                  halted,
    output cpu_pkg::addr_t        pc
);

    cpu_pkg::instr_t   instr;
    cpu_pkg::flags_t   flags;
    cpu_pkg::flags_t   alu_flags;
    cpu_pkg::alu_op_t  alu_op;
    logic [7:0]        a_sel;
    logic [7:0]        b_sel;
    logic [15:0]       targ_we;
    logic              set_flags;
    cpu_pkg::byte_t    immed;
    cpu_pkg::byte_t    ram_addr;
    cpu_pkg::byte_t    ram_rdata;
    cpu_pkg::byte_t    result;
    cpu_pkg::byte_t    rega, regb, regc, regd;
    cpu_pkg::byte_t    marlo, marhi;
    cpu_pkg::byte_t    a_src [8];
    cpu_pkg::byte_t    b_src [8];
    cpu_pkg::byte_t    a_bus;
    cpu_pkg::byte_t    b_bus;

    // OR of masked sources, select is one-hot
    function automatic cpu_pkg::byte_t onehot_mux(input logic [7:0] sel,
                                                  input cpu_pkg::byte_t src [8]);
        cpu_pkg::byte_t y;
        y = '0;
        for (int i = 0; i < 8; i++) begin
            if (sel[i]) begin
                y |= src[i];
            end
        end
        return y;
    endfunction

    // ----------------------------------------
    // Bus sources by device code
    always_comb begin
        a_src[`DEV_REGA]   = rega;
        a_src[`DEV_REGB]   = regb;
        a_src[`DEV_REGC]   = regc;
        a_src[`DEV_REGD]   = regd;
        a_src[`DEV_MARLO]  = marlo;
        a_src[`DEV_MARHI]  = marhi;
        a_src[`ADEV_RAM]   = ram_rdata;
        a_src[`ADEV_ZERO]  = '0;
        b_src[`DEV_REGA]   = rega;
        b_src[`DEV_REGB]   = regb;
        b_src[`DEV_REGC]   = regc;
        b_src[`DEV_REGD]   = regd;
        b_src[`DEV_MARLO]  = marlo;
        b_src[`DEV_MARHI]  = marhi;
        b_src[`BDEV_IMMED] = immed;       // Constant from the word
        b_src[`BDEV_RAM]   = ram_rdata;
    end

    assign a_bus = onehot_mux(a_sel, a_src);
    assign b_bus = onehot_mux(b_sel, b_src);

    // ----------------------------------------
    // Blocks
    program_rom u_rom (
        .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .pc(pc), .instr(instr)
    );

    controller u_ctrl (
        .instr(instr), .flags(flags), .out_ready(out_ready), .run(run),
        .halted(halted), .marlo(marlo), .marhi(marhi), .alu_op(alu_op),
        .a_sel(a_sel), .b_sel(b_sel), .immed(immed), .targ_we(targ_we),
        .set_flags(set_flags), .ram_addr(ram_addr)
    );

    alu u_alu (
        .a(a_bus), .b(b_bus), .carry_in(flags[`FLAG_C]), .op(alu_op),
        .result(result), .flags_out(alu_flags)
    );

    register_file u_regs (
        .clk(clk), .rst(rst), .targ_we(targ_we), .set_flags(set_flags),
        .result(result), .alu_flags(alu_flags),
        .rega(rega), .regb(regb), .regc(regc), .regd(regd),
        .marlo(marlo), .marhi(marhi), .flags(flags),
        .out_data(out_data), .out_valid(out_valid)
    );

    data_ram u_ram (
        .clk(clk), .we(targ_we[`TDEV_RAM]), .addr(ram_addr), .wdata(result),
        .rdata(ram_rdata)
    );

    program_counter u_pc (
        .clk(clk), .rst(rst), .run(run), .targ_we(targ_we), .result(result),
        .pc(pc), .halted(halted)
    );

endmodule

`default_nettype wire

//--- cpu_checker.sv
/* Concurrent assertions on the output port, reset and halt of the core.
   Bound into cpu_core by the bind at the bottom of this file */
`default_nettype none

`include "cpu_defs.svh"

module cpu_checker (
    input wire                  clk,
    input wire                  rst,
    input wire                  out_valid,
    input wire                  out_ready,
    input wire                  halted,
    input wire                  uart_we,     // Executed uart write
    input wire cpu_pkg::addr_t  pc
);

    int error_count = 0;   // Failed assertions so far

    // Port silent through reset and one cycle after
    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        error_count++;
        $error("out_valid high during or just after reset");
    end

    a_halt_hold: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
    else begin
        error_count++;
        $error("pc moved while halted");
    end

    // A second strobe cycle needs a second write
    a_strobe_width: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> (!out_valid || $past(uart_we)))
    else begin
        error_count++;
        $error("out_valid held without a new uart write");
    end

    // Poll sees ready, then the write, then the strobe
    a_polled: assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(out_ready, 2))
    else begin
        error_count++;
        $error("out_valid without out_ready in the polling cycle");
    end

endmodule

bind cpu_core cpu_checker chk0 (
    .clk(clk), .rst(rst), .out_valid(out_valid), .out_ready(out_ready),
    .halted(halted), .uart_we(targ_we[`TDEV_UART]), .pc(pc)
);

`default_nettype wire

//--- tb_cpu_core.sv
/* Testbench for cpu_core. Reads programs and expected output bytes from
   cpu_patterns.txt, runs each one under a random out_ready and checks the port */
`default_nettype none

module tb_cpu_core;

    localparam int SEED       = 49689;
    localparam int RST_CYCLES = 10;
    localparam int SETTLE     = 4;       // Quiet cycles watched after halt

    logic             clk;
    logic             rst;
    logic             run;
    logic             prog_we;
    cpu_pkg::addr_t   prog_addr;
    cpu_pkg::instr_t  prog_data;
    logic             out_ready;
    cpu_pkg::byte_t   out_data;
    logic             out_valid;
    logic             halted;
    cpu_pkg::addr_t   pc;

    // Parsed pattern file
    string            tname [$];
    int               wstart [$];        // First word of each test, plus a sentinel
    int               ostart [$];        // First byte of each test, plus a sentinel
    cpu_pkg::addr_t   end_pc [$];        // pc expected once halted
    cpu_pkg::addr_t   waddr [$];
    cpu_pkg::instr_t  wdata [$];
    cpu_pkg::byte_t   obytes [$];
    int               limit_cycles = 0;

    cpu_core dut0 (
        .clk(clk), .rst(rst), .run(run),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .out_ready(out_ready), .out_data(out_data), .out_valid(out_valid),
        .halted(halted), .pc(pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sink readiness, a new coin flip each falling edge
    initial begin
        out_ready = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            out_ready = 1'($urandom_range(1, 0));
        end
    end

    // ----------------------------------------
    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_byte(input string what, input cpu_pkg::byte_t exp,
                                input cpu_pkg::byte_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic compare_addr(input string what, input cpu_pkg::addr_t exp,
                                input cpu_pkg::addr_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic read_patterns();
        int           fd;
        int           n;
        string        line;
        string        kind;
        string        name;
        logic [15:0]  a;
        logic [47:0]  d;
        logic [7:0]   b;
        fd = $fopen("cpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open cpu_patterns.txt for reading");
            stop_on_error();
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", kind);
                if (n == 1 && kind.substr(0, 0) != "#") begin   // Skip blanks and notes
                    case (kind)
                        "test": begin
                            n = $sscanf(line, "%s %s", kind, name);
                            tname.push_back(name);
                            wstart.push_back(waddr.size());
                            ostart.push_back(obytes.size());
                        end
                        "w": begin
                            n = $sscanf(line, "%s %h %h", kind, a, d);
                            waddr.push_back(a);
                            wdata.push_back(d);
                        end
                        "o": begin
                            n = $sscanf(line, "%s %h", kind, b);
                            obytes.push_back(b);
                        end
                        "end": begin
                            n = $sscanf(line, "%s %h", kind, a);
                            end_pc.push_back(a);
                        end
                        default: begin
                            $display("Unknown record %s in cpu_patterns.txt", kind);
                            stop_on_error();
                        end
                    endcase
                end
            end
            $fclose(fd);
            wstart.push_back(waddr.size());       // Sentinels close the last test
            ostart.push_back(obytes.size());
        end
    endtask

    // One falling edge, picking up a byte if the port strobes
    task automatic sample_port(input int t, inout int n_got);
        @(negedge clk);
        if (out_valid) begin
            if (n_got >= ostart[t+1] - ostart[t]) begin
                $display("Test %s put out a byte beyond the expected %0d",
                         tname[t], ostart[t+1] - ostart[t]);
                stop_on_error();
            end else begin
                compare_byte($sformatf("%s byte %0d", tname[t], n_got),
                             obytes[ostart[t] + n_got], out_data);
                n_got++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int n_got;
        int k;
        n_got = 0;
        @(negedge clk);
        run = 1'b0;
        rst = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        compare_addr({tname[t], " pc after reset"}, cpu_pkg::addr_t'(0), pc);

        // Program load, one word per cycle
        for (k = wstart[t]; k < wstart[t+1]; k++) begin
            prog_we   = 1'b1;
            prog_addr = waddr[k];
            prog_data = wdata[k];
            @(negedge clk);
        end
        prog_we = 1'b0;
        run     = 1'b1;

        while (!halted) begin
            sample_port(t, n_got);
        end
        repeat (SETTLE) sample_port(t, n_got);   // Nothing more may come out

        if (n_got != ostart[t+1] - ostart[t]) begin
            $display("Test %s put out %0d bytes where %0d were expected",
                     tname[t], n_got, ostart[t+1] - ostart[t]);
            stop_on_error();
        end else begin
            compare_addr({tname[t], " pc after halt"}, end_pc[t], pc);
            run = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Watchdog, armed once the pattern file has been read
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
        stop_on_error();
    end

    // First assertion failure in the bound checker ends the run
    initial begin
        wait (dut0.chk0.error_count != 0);
        $display("An assertion in the checker failed, see the error above");
        stop_on_error();
    end

    initial begin
        int t;
        rst       = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_patterns();
        limit_cycles = waddr.size() * 64 + 200;
        for (t = 0; t < tname.size(); t++) begin
            run_test(t);
            $display("Test %s done", tname[t]);
        end
        if (dut0.chk0.error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Checker saw %0d assertion failures", dut0.chk0.error_count);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- cpu_patterns.txt
# Records: "test <name>", "w <addr hex> <48-bit word hex>", "o <expected byte hex>",
# "end <pc hex once halted>". Every uart write is preceded by a poll on inverted DO.
test imm_moves
w 0000 100c00000011
w 0001 108c00000022
w 0002 110c00000033
w 0003 118c00000044
w 0004 148d28000004
w 0005 0b8000000000
w 0006 148d28000006
w 0007 0b9000000000
w 0008 148d28000008
w 0009 0ba000000000
w 000a 148d2800000a
w 000b 0bb000000000
w 000c 050000000000
o 11
o 22
o 33
o 44
end 000d

test alu_flags
w 0000 100c000000f0
w 0001 108c00000020
w 0002 190210000000
w 0003 148d28000003
w 0004 0ba020000000
w 0005 148d28000005
w 0006 138c480000e1
w 0007 148d28000007
w 0008 138c400000e2
w 0009 148d28000009
w 000a 138ca00000e3
w 000b 148d2800000b
w 000c 138cc00000e4
w 000d 100c00000080
w 000e 218c10000001
w 000f 148d2800000f
w 0010 0bb060000000
w 0011 148d28000011
w 0012 138c280000e7
w 0013 509210000000
w 0014 148d28000014
w 0015 138ce00000e9
w 0016 148d28000016
w 0017 138d000000eb
w 0018 697c10000005
w 0019 148d28000019
w 001a 0ba080000000
w 001b 71ac00000003
w 001c 148d2800001c
w 001d 0bb000000000
w 001e 050000000000
o 10
o e1
o e3
o 7f
o e7
o e9
o ff
o fd
end 001f

test ram_modes
w 0000 128c00000001
w 0001 120c00000040
w 0002 130c0000005a
w 0003 130c010041a5
w 0004 100c00000003
w 0005 148d28000005
w 0006 0be000000000
w 0007 120c00000041
w 0008 148d28000008
w 0009 0be000000000
w 000a 148d2800000a
w 000b 0be001004000
w 000c 148d2800000c
w 000d 1b8e01004000
w 000e 050000000000
o 5a
o a5
o 5a
o 5d
end 000f

test countdown
w 0000 140c00000001
w 0001 100c00000003
w 0002 148c00000000
w 0100 148d28000000
w 0101 0b8000000000
w 0102 680010000000
w 0103 148c48000000
w 0104 050000000000
o 03
o 02
o 01
end 0105

test do_polling
w 0000 148d28000000
w 0001 138c000000c1
w 0002 148d28000002
w 0003 138c000000c2
w 0004 148d28000004
w 0005 138c000000c3
w 0006 050000000000
o c1
o c2
o c3
end 0007

test halt_stop
w 0000 050040000000
w 0001 148d28000001
w 0002 138c00000077
w 0003 050000000000
w 0004 138c00000088
o 77
end 0004

//--- sources.f
+incdir+.
cpu_pkg.sv
program_rom.sv
controller.sv
alu.sv
register_file.sv
data_ram.sv
program_counter.sv
cpu_core.sv
cpu_checker.sv
tb_cpu_core.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - program_rom.sv
      - controller.sv
      - alu.sv
      - register_file.sv
      - data_ram.sv
      - program_counter.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpu_checker.sv
      - tb_cpu_core.sv
